/* udp_echo_pkg.sv */
// UDP echo shared definitions
`default_nettype none

package udp_echo_pkg;

    // Basic field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Payload stream widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // Port that gets answered
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Fixed reply fields, filled in by the downstream UDP stack
    localparam ip_addr_t    LOCAL_IP       = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]  REPLY_TTL      = 8'd64;
    localparam logic [5:0]  REPLY_DSCP     = 6'd0;
    localparam logic [1:0]  REPLY_ECN      = 2'd0;
    localparam logic [15:0] REPLY_CHECKSUM = 16'd0;

    // Buffering
    localparam int HDR_FIFO_DEPTH     = 4;
    localparam int PAYLOAD_FIFO_DEPTH = 64;

    // One payload beat, 74 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } payload_beat_t;

    // Reply header handed to the UDP transmit side, 80 bits
    typedef struct packed {
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        logic [15:0] length;
    } reply_hdr_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
// Valid/ready FIFO
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  wire    clk,
    input  wire    rst,
    input  wire    push_valid,
    input  wire T  push_data,
    output logic   push_ready,
    output logic   pop_valid,
    output T       pop_data,
    input  wire    pop_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic           push_fire;
    logic           out_load;
    logic           ring_read;
    logic           ring_write;

    // Pointer wrap that also handles depths which are not a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_fire  = push_valid && push_ready;
    // Output register is free or being emptied this cycle
    assign out_load   = !pop_valid || pop_ready;
    assign ring_read  = out_load && (count != '0);
    // Empty ring with a free output register takes the bypass path
    assign ring_write = push_fire && !(out_load && (count == '0));

    always_comb begin
        count_next = count;
        if (ring_write && !ring_read) begin
            count_next = count + 1'b1;
        end else if (ring_read && !ring_write) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ring_write) begin
            mem[wr_ptr] <= push_data;
        end
        if (out_load) begin
            if (ring_read) begin
                pop_data <= mem[rd_ptr];
            end else if (push_fire) begin
                pop_data <= push_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            push_ready <= 1'b0;
            pop_valid  <= 1'b0;
        end else begin
            count      <= count_next;
            push_ready <= (count_next < CW'(DEPTH));
            if (ring_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (ring_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (out_load) begin
                pop_valid <= ring_read || push_fire;
            end
        end
    end

endmodule

`default_nettype wire

/* udp_echo_filter.sv */
// UDP echo frame filter
`timescale 1ns/1ps
`default_nettype none

module udp_echo_filter (
    input  wire                               clk,
    input  wire                               rst,

    // Received UDP header
    input  wire                               in_hdr_valid,
    output logic                              in_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t       in_source_ip,
    input  wire udp_echo_pkg::udp_port_t      in_source_port,
    input  wire udp_echo_pkg::udp_port_t      in_dest_port,
    input  wire [15:0]                        in_length,

    // Received payload control
    input  wire                               in_valid,
    output logic                              in_ready,
    input  wire                               in_last,

    // Reply header toward its FIFO
    output logic                              hdr_push_valid,
    output udp_echo_pkg::reply_hdr_t          hdr_push,
    input  wire                               hdr_push_ready,

    // Payload gating toward its FIFO
    output logic                              beat_push_valid,
    input  wire                               beat_push_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DISCARD
    } state_t;

    state_t state;
    logic   armed;
    logic   match;
    logic   hdr_open;
    logic   hdr_fire;
    logic   beat_fire;

    assign match = (in_dest_port == udp_echo_pkg::ECHO_PORT);

    // Header side only listens between frames, and not in the cycle after reset
    assign hdr_open = (state == ST_IDLE) && armed;

    assign in_hdr_ready   = hdr_open && (hdr_push_ready || !match);
    assign hdr_push_valid = hdr_open && in_hdr_valid && match;
    assign hdr_fire       = in_hdr_valid && in_hdr_ready;

    // Reply goes back to the sender with the ports swapped
    assign hdr_push.dest_ip     = in_source_ip;
    assign hdr_push.source_port = in_dest_port;
    assign hdr_push.dest_port   = in_source_port;
    assign hdr_push.length      = in_length;

    // Matching frames stall on the payload FIFO, others drain freely
    assign beat_push_valid = (state == ST_FORWARD) && in_valid;
    assign in_ready        = (state == ST_DISCARD) ||
                             ((state == ST_FORWARD) && beat_push_ready);
    assign beat_fire       = in_valid && in_ready && in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        state <= match ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    if (beat_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* led_capture.sv */
// First payload byte LED latch
`timescale 1ns/1ps
`default_nettype none

module led_capture (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              out_valid,
    input  wire                              out_ready,
    input  wire                              out_last,
    input  wire [udp_echo_pkg::DATA_W-1:0]   out_data,
    output logic [7:0]                       led
);

    logic first_beat;
    logic beat_fire;

    assign beat_fire = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= 8'd0;
        end else if (beat_fire) begin
            // Next transfer opens a new frame once this one ends
            first_beat <= out_last;
            if (first_beat) begin
                led <= out_data[7:0];
            end
        end
    end

endmodule

`default_nettype wire

/* udp_echo_core.sv */
// UDP echo core
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core (
    input  wire                                  clk,
    input  wire                                  rst,

    // Received UDP header
    input  wire                                  in_hdr_valid,
    output logic                                 in_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t          in_source_ip,
    input  wire udp_echo_pkg::udp_port_t         in_source_port,
    input  wire udp_echo_pkg::udp_port_t         in_dest_port,
    input  wire [15:0]                           in_length,

    // Received payload
    input  wire                                  in_valid,
    output logic                                 in_ready,
    input  wire [udp_echo_pkg::DATA_W-1:0]       in_data,
    input  wire [udp_echo_pkg::KEEP_W-1:0]       in_keep,
    input  wire                                  in_last,
    input  wire                                  in_user,

    // Reply header
    output logic                                 out_hdr_valid,
    input  wire                                  out_hdr_ready,
    output udp_echo_pkg::ip_addr_t               out_dest_ip,
    output udp_echo_pkg::udp_port_t              out_source_port,
    output udp_echo_pkg::udp_port_t              out_dest_port,
    output logic [15:0]                          out_length,

    // Reply payload
    output logic                                 out_valid,
    input  wire                                  out_ready,
    output logic [udp_echo_pkg::DATA_W-1:0]      out_data,
    output logic [udp_echo_pkg::KEEP_W-1:0]      out_keep,
    output logic                                 out_last,
    output logic                                 out_user,

    output logic [7:0]                           led
);

    udp_echo_pkg::reply_hdr_t    hdr_push;
    udp_echo_pkg::reply_hdr_t    hdr_pop;
    logic                        hdr_push_valid;
    logic                        hdr_push_ready;

    udp_echo_pkg::payload_beat_t beat_push;
    udp_echo_pkg::payload_beat_t beat_pop;
    logic                        beat_push_valid;
    logic                        beat_push_ready;

    udp_echo_filter u_filter (
        .clk             (clk),
        .rst             (rst),
        .in_hdr_valid    (in_hdr_valid),
        .in_hdr_ready    (in_hdr_ready),
        .in_source_ip    (in_source_ip),
        .in_source_port  (in_source_port),
        .in_dest_port    (in_dest_port),
        .in_length       (in_length),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_last         (in_last),
        .hdr_push_valid  (hdr_push_valid),
        .hdr_push        (hdr_push),
        .hdr_push_ready  (hdr_push_ready),
        .beat_push_valid (beat_push_valid),
        .beat_push_ready (beat_push_ready)
    );

    stream_fifo #(
        .T     (udp_echo_pkg::reply_hdr_t),
        .DEPTH (udp_echo_pkg::HDR_FIFO_DEPTH)
    ) u_hdr_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (hdr_push_valid),
        .push_data  (hdr_push),
        .push_ready (hdr_push_ready),
        .pop_valid  (out_hdr_valid),
        .pop_data   (hdr_pop),
        .pop_ready  (out_hdr_ready)
    );

    // Payload fields pass to the FIFO untouched, only valid is gated
    assign beat_push.data = in_data;
    assign beat_push.keep = in_keep;
    assign beat_push.last = in_last;
    assign beat_push.user = in_user;

    stream_fifo #(
        .T     (udp_echo_pkg::payload_beat_t),
        .DEPTH (udp_echo_pkg::PAYLOAD_FIFO_DEPTH)
    ) u_payload_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (beat_push_valid),
        .push_data  (beat_push),
        .push_ready (beat_push_ready),
        .pop_valid  (out_valid),
        .pop_data   (beat_pop),
        .pop_ready  (out_ready)
    );

    assign out_dest_ip     = hdr_pop.dest_ip;
    assign out_source_port = hdr_pop.source_port;
    assign out_dest_port   = hdr_pop.dest_port;
    assign out_length      = hdr_pop.length;

    assign out_data = beat_pop.data;
    assign out_keep = beat_pop.keep;
    assign out_last = beat_pop.last;
    assign out_user = beat_pop.user;

    led_capture u_led (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_data  (out_data),
        .led       (led)
    );

endmodule

`default_nettype wire

/* tb_udp_echo_model.svh */
// Echo reference model
`ifndef TB_UDP_ECHO_MODEL_SVH
`define TB_UDP_ECHO_MODEL_SVH

// Expected reply headers as {dest_ip, source_port, dest_port, length}
logic [79:0] exp_hdr_q[$];
// Expected output beats as {data, keep, last, user}
logic [73:0] exp_beat_q[$];

// Frames for port 1234 go back to the sender with the ports swapped
function automatic bit reply_model(
    input  logic [31:0] source_ip,
    input  logic [15:0] source_port,
    input  logic [15:0] dest_port,
    input  logic [15:0] length,
    output logic [79:0] reply
);
    reply = {source_ip, dest_port, source_port, length};
    return (dest_port == 16'd1234);
endfunction

`endif

/* tb_udp_echo_core.sv */
// UDP echo core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo_core;

    localparam int CYCLE_LIMIT   = 20000;
    localparam int RANDOM_FRAMES = 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_hdr_valid, in_hdr_ready, in_valid, in_ready, in_last, in_user;
    logic [31:0] in_source_ip;
    logic [15:0] in_source_port, in_dest_port, in_length;
    logic [63:0] in_data;
    logic [7:0]  in_keep;
    logic        out_hdr_valid, out_hdr_ready, out_valid, out_ready, out_last, out_user;
    logic [31:0] out_dest_ip;
    logic [15:0] out_source_port, out_dest_port, out_length;
    logic [63:0] out_data;
    logic [7:0]  out_keep;
    logic [7:0]  led;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    bit          bp_on = 1'b0;
    bit          led_pending = 1'b0;
    bit          mon_first = 1'b1;
    logic [7:0]  led_expect;

    `include "tb_udp_echo_model.svh"

    udp_echo_core u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic value_error(input string what, input logic [79:0] got,
                               input logic [79:0] exp);
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // Random consumer stalls on both output streams
    always @(negedge clk) begin
        if (bp_on) begin
            out_ready     = ($urandom_range(0, 1) == 1);
            out_hdr_ready = ($urandom_range(0, 3) != 0);
        end else begin
            out_ready     = 1'b1;
            out_hdr_ready = 1'b1;
        end
    end

    // Compares every output transfer against the expected queues
    always @(posedge clk) begin
        logic [79:0] exp_hdr;
        logic [73:0] exp_beat;
        if (!rst) begin
            // LED is checked one cycle after the frame's last beat left
            if (led_pending) begin
                checks++;
                if (led !== led_expect) begin
                    value_error("led", 80'(led), 80'(led_expect));
                end
                led_pending = 1'b0;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    errors++;
                    $display("Reply header at %0t with no echoed frame pending", $time);
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    checks++;
                    if ({out_dest_ip, out_source_port, out_dest_port, out_length} !== exp_hdr) begin
                        value_error("reply header",
                            {out_dest_ip, out_source_port, out_dest_port, out_length}, exp_hdr);
                    end
                end
            end
            if (out_valid && out_ready) begin
                if (exp_beat_q.size() == 0) begin
                    errors++;
                    $display("Output beat at %0t with no echoed payload pending", $time);
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    checks++;
                    if ({out_data, out_keep, out_last, out_user} !== exp_beat) begin
                        value_error("payload beat",
                            80'({out_data, out_keep, out_last, out_user}), 80'(exp_beat));
                    end
                    if (mon_first) begin
                        led_expect = exp_beat[17:10];
                    end
                    mon_first = exp_beat[1];
                    led_pending = exp_beat[1];
                end
            end
        end
    end

    task automatic send_frame(input logic [15:0] dest_port, input int nbeats);
        logic [79:0] reply;
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
        bit          echo;
        @(negedge clk);
        in_valid       = 1'b0;
        in_hdr_valid   = 1'b1;
        in_source_ip   = $urandom;
        in_source_port = 16'($urandom);
        in_dest_port   = dest_port;
        in_length      = 16'(nbeats * 8);
        echo = reply_model(in_source_ip, in_source_port, dest_port, in_length, reply);
        if (echo) begin
            exp_hdr_q.push_back(reply);
        end
        @(posedge clk);
        while (!in_hdr_ready) begin
            @(posedge clk);
        end
        for (int i = 0; i < nbeats; i++) begin
            last = (i == nbeats - 1);
            data = {$urandom, $urandom};
            keep = last ? 8'((9'd1 << $urandom_range(1, 8)) - 9'd1) : 8'hff;
            user = 1'($urandom_range(0, 1));
            @(negedge clk);
            if (echo) begin
                exp_beat_q.push_back({data, keep, last, user});
            end
            in_hdr_valid = 1'b0;
            in_valid     = 1'b1;
            in_data      = data;
            in_keep      = keep;
            in_last      = last;
            in_user      = user;
            @(posedge clk);
            while (!in_ready) begin
                if (!echo) begin
                    errors++;
                    $display("Dropped frame stalled its payload at %0t", $time);
                end
                @(posedge clk);
            end
        end
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        in_hdr_valid = 1'b0;
        in_valid     = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 || led_pending) begin
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(80543));
        rst            = 1'b1;
        in_hdr_valid   = 1'b0;
        in_source_ip   = '0;
        in_source_port = '0;
        in_dest_port   = '0;
        in_length      = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_keep        = '0;
        in_last        = 1'b0;
        in_user        = 1'b0;
        out_hdr_ready  = 1'b1;
        out_ready      = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet outputs and a clear LED straight out of reset
        @(posedge clk);
        checks++;
        if (out_hdr_valid !== 1'b0 || out_valid !== 1'b0 || in_hdr_ready !== 1'b0 ||
                in_ready !== 1'b0 || led !== 8'd0) begin
            errors++;
            $display("** Error at %0t: outputs not idle after reset", $time);
        end

        send_frame(16'd1234, 3);
        idle_inputs();
        wait_drain();

        // The monitor flags any output from a non-matching port
        send_frame(16'd80, 2);
        idle_inputs();
        repeat (16) @(negedge clk);

        bp_on = 1'b1;
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            if ($urandom_range(0, 1) == 1) begin
                send_frame(16'd1234, $urandom_range(1, 8));
            end else begin
                send_frame(16'($urandom_range(1235, 65535)), $urandom_range(1, 8));
            end
        end
        idle_inputs();
        wait_drain();
        bp_on = 1'b0;

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_echo_core.f */
+incdir+.
udp_echo_pkg.sv
stream_fifo.sv
udp_echo_filter.sv
led_capture.sv
udp_echo_core.sv
tb_udp_echo_core.sv

/* Bender.yml */
package:
  name: udp_echo_core

sources:
  - udp_echo_pkg.sv
  - stream_fifo.sv
  - udp_echo_filter.sv
  - led_capture.sv
  - udp_echo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_echo_core.sv
